// File: include/vend_params.svh
`ifndef VEND_PARAMS_SVH
`define VEND_PARAMS_SVH

// product prices in credit units
`define VEND_PRICE_COKE   8'd10
`define VEND_PRICE_WATER  8'd12
`define VEND_PRICE_JUICE  8'd15

// stock after reset
`define VEND_INIT_COKE    4'd5
`define VEND_INIT_WATER   4'd1
`define VEND_INIT_JUICE   4'd0

// restock stops here
`define VEND_STOCK_MAX    4'd9

// coin values
`define VEND_COIN_SMALL   8'd1
`define VEND_COIN_MID     8'd5
`define VEND_COIN_LARGE   8'd10

// balance saturates here
`define VEND_CREDIT_MAX   8'd99

// clock cycles per paid-out unit, small for simulation
`define VEND_PAYOUT_DIV   4

`endif

// File: hdl/vend_pkg.sv
`include "vend_params.svh"

package vend_pkg;

    // cursor position is item index minus one
    typedef enum logic [1:0] {
        ITEM_NONE,
        ITEM_COKE,
        ITEM_WATER,
        ITEM_JUICE
    } item_e;

    typedef enum logic {
        LEDGER_IDLE,
        LEDGER_PAYOUT
    } ledger_state_e;

    typedef enum logic [1:0] {
        COIN_NONE,
        COIN_SMALL,
        COIN_MID,
        COIN_LARGE
    } coin_e;

    // one-shot key pulses, at most one set per cycle
    typedef struct packed {
        logic  up;
        logic  down;
        logic  select;
        coin_e coin;
        logic  buy;
        logic  ret;
        logic  restock;
    } vend_keys_t;

    typedef struct packed {
        logic  valid;
        item_e item;
    } vend_grant_t;

    typedef struct packed {
        item_e      item;
        logic [3:0] stock;
    } sel_status_t;

    function automatic logic [7:0] item_price(input item_e item);
        case (item)
            ITEM_COKE:  return `VEND_PRICE_COKE;
            ITEM_WATER: return `VEND_PRICE_WATER;
            ITEM_JUICE: return `VEND_PRICE_JUICE;
            default:    return 8'd0;
        endcase
    endfunction

endpackage

// File: hdl/item_select.sv
`timescale 1ns/1ps
`include "vend_params.svh"

module item_select (
    input  logic                  clk,
    input  logic                  rst,
    input  vend_pkg::vend_keys_t  keys,
    input  logic                  admin_mode,
    input  vend_pkg::vend_grant_t grant,
    output logic [1:0]            cursor,
    output logic [3:0]            stock_shown,
    output vend_pkg::sel_status_t status
);
    import vend_pkg::*;

    item_e      sel_item;
    item_e      cursor_item;
    logic [3:0] stock [0:2];
    logic [1:0] sel_idx;
    logic [1:0] vend_idx;
    logic       move_key;
    // coin, buy or ret present, restock loses to them
    logic       low_key;

    assign move_key    = keys.up | keys.down;
    assign low_key     = (keys.coin != COIN_NONE) | keys.buy | keys.ret;
    assign cursor_item = item_e'(cursor + 2'd1);
    assign sel_idx     = 2'(sel_item) - 2'd1;
    assign vend_idx    = 2'(grant.item) - 2'd1;

    //////////////////////////////////////////////////////////////////////
    // cursor, selection and stock counts
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor   <= 2'd0;
            sel_item <= ITEM_NONE;
            stock[0] <= `VEND_INIT_COKE;
            stock[1] <= `VEND_INIT_WATER;
            stock[2] <= `VEND_INIT_JUICE;
        end else if (move_key) begin
            // up wins over down, both saturate
            if (keys.up) begin
                if (cursor != 2'd0) begin
                    cursor <= cursor - 2'd1;
                end
            end else if (cursor != 2'd2) begin
                cursor <= cursor + 2'd1;
            end
        end else if (keys.select) begin
            if (sel_item == cursor_item) begin
                sel_item <= ITEM_NONE;
            end else if (stock[cursor] != 4'd0) begin
                // sold out items cannot be selected
                sel_item <= cursor_item;
            end
        end else if (grant.valid) begin
            // arbiter already checked stock and credit
            stock[vend_idx] <= stock[vend_idx] - 4'd1;
            sel_item        <= ITEM_NONE;
        end else if (keys.restock && admin_mode && !low_key) begin
            if (stock[cursor] < `VEND_STOCK_MAX) begin
                stock[cursor] <= stock[cursor] + 4'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // status toward the arbiter
    //////////////////////////////////////////////////////////////////////

    assign stock_shown = stock[cursor];

    always_comb begin
        status.item  = sel_item;
        status.stock = 4'd0;
        if (sel_item != ITEM_NONE) begin
            status.stock = stock[sel_idx];
        end
    end

endmodule

// File: hdl/credit_ledger.sv
`timescale 1ns/1ps
`include "vend_params.svh"

module credit_ledger (
    input  logic                  clk,
    input  logic                  rst,
    input  vend_pkg::vend_keys_t  keys,
    input  vend_pkg::vend_grant_t grant,
    output logic [7:0]            credit,
    output logic                  payout,
    output logic                  returning
);
    import vend_pkg::*;

    localparam int DIV_W = $clog2(`VEND_PAYOUT_DIV + 1);

    ledger_state_e    state;
    logic [DIV_W-1:0] div_cnt;
    logic             div_done;
    logic [7:0]       coin_val;
    logic [8:0]       coin_sum;
    // keys that outrank a coin or a return
    logic             above_coin;
    logic             above_ret;

    assign above_coin = keys.up | keys.down | keys.select;
    assign above_ret  = above_coin | (keys.coin != COIN_NONE) | keys.buy;
    assign div_done   = (div_cnt == DIV_W'(`VEND_PAYOUT_DIV - 1));
    assign returning  = (state == LEDGER_PAYOUT);

    always_comb begin
        case (keys.coin)
            COIN_SMALL: coin_val = `VEND_COIN_SMALL;
            COIN_MID:   coin_val = `VEND_COIN_MID;
            COIN_LARGE: coin_val = `VEND_COIN_LARGE;
            default:    coin_val = 8'd0;
        endcase
    end

    // one extra bit so the saturation test sees overflow past the limit
    assign coin_sum = {1'b0, credit} + {1'b0, coin_val};

    //////////////////////////////////////////////////////////////////////
    // ledger FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= LEDGER_IDLE;
            credit  <= 8'd0;
            div_cnt <= '0;
            payout  <= 1'b0;
        end else begin
            payout <= 1'b0;
            case (state)
                LEDGER_IDLE: begin
                    div_cnt <= '0;
                    if (!above_coin && keys.coin != COIN_NONE) begin
                        if (coin_sum > {1'b0, `VEND_CREDIT_MAX}) begin
                            credit <= `VEND_CREDIT_MAX;
                        end else begin
                            credit <= coin_sum[7:0];
                        end
                    end else if (grant.valid) begin
                        credit <= credit - item_price(grant.item);
                    end else if (keys.ret && !above_ret && credit != 8'd0) begin
                        state <= LEDGER_PAYOUT;
                    end
                end
                LEDGER_PAYOUT: begin
                    // coins are dropped here, buys are never granted
                    if (credit == 8'd0) begin
                        state <= LEDGER_IDLE;
                    end else if (div_done) begin
                        div_cnt <= '0;
                        credit  <= credit - 8'd1;
                        payout  <= 1'b1;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/vend_arbiter.sv
`timescale 1ns/1ps

module vend_arbiter (
    input  vend_pkg::vend_keys_t  keys,
    input  vend_pkg::sel_status_t status,
    input  logic [7:0]            credit,
    input  logic                  returning,
    output vend_pkg::vend_grant_t grant
);
    import vend_pkg::*;

    logic [7:0] price;
    logic       buy_key;
    logic       in_stock;
    logic       paid;

    assign price = item_price(status.item);

    // buy counts only when nothing of higher priority is pressed
    assign buy_key = keys.buy & ~keys.up & ~keys.down & ~keys.select
                   & (keys.coin == COIN_NONE);

    assign in_stock = (status.item != ITEM_NONE) && (status.stock != 4'd0);
    assign paid     = (credit >= price);

    always_comb begin
        grant.valid = buy_key && in_stock && paid && !returning;
        grant.item  = ITEM_NONE;
        if (grant.valid) begin
            grant.item = status.item;
        end
    end

endmodule

// File: hdl/vend_top.sv
`timescale 1ns/1ps

module vend_top (
    input  logic                 clk,
    input  logic                 rst,
    input  vend_pkg::vend_keys_t keys,
    input  logic                 admin_mode,
    output logic [7:0]           credit,
    output logic [1:0]           cursor,
    output vend_pkg::item_e      selected,
    output logic [3:0]           stock_shown,
    output logic                 vend,
    output vend_pkg::item_e      vend_item,
    output logic                 payout,
    output logic                 returning
);
    import vend_pkg::*;

    vend_grant_t grant;
    sel_status_t status;

    item_select u_item_select (
        .clk         (clk),
        .rst         (rst),
        .keys        (keys),
        .admin_mode  (admin_mode),
        .grant       (grant),
        .cursor      (cursor),
        .stock_shown (stock_shown),
        .status      (status)
    );

    credit_ledger u_credit_ledger (
        .clk       (clk),
        .rst       (rst),
        .keys      (keys),
        .grant     (grant),
        .credit    (credit),
        .payout    (payout),
        .returning (returning)
    );

    // grant is combinational, both units apply it at the same edge
    vend_arbiter u_vend_arbiter (
        .keys      (keys),
        .status    (status),
        .credit    (credit),
        .returning (returning),
        .grant     (grant)
    );

    assign vend      = grant.valid;
    assign vend_item = grant.item;
    assign selected  = status.item;

endmodule

// File: tb/vend_chk.sv
`timescale 1ns/1ps
`include "vend_params.svh"

module vend_chk (
    input logic       clk,
    input logic       rst,
    input logic [7:0] credit,
    input logic [1:0] cursor,
    input logic       vend,
    input logic       payout,
    input logic       returning
);

    payout_in_return: assert property (@(posedge clk) disable iff (!rst)
        payout |-> returning) else $error("payout pulse outside a return");

    // vend follows the one-cycle buy key
    vend_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        vend |=> !vend) else $error("vend held longer than one cycle");

    credit_limit: assert property (@(posedge clk) disable iff (!rst)
        credit <= `VEND_CREDIT_MAX) else $error("credit above its limit");

    cursor_range: assert property (@(posedge clk) disable iff (!rst)
        cursor <= 2'd2) else $error("cursor past the last product");

endmodule

bind vend_top vend_chk u_vend_chk (.*);

// File: tb/vend_tb.sv
`timescale 1ns/1ps
`include "vend_params.svh"

module vend_tb;
    import vend_pkg::*;

    logic       clk;
    logic       rst;
    vend_keys_t keys;
    logic       admin_mode;
    logic [7:0] credit;
    logic [1:0] cursor;
    item_e      selected;
    logic [3:0] stock_shown;
    logic       vend;
    item_e      vend_item;
    logic       payout;
    logic       returning;

    // rows hold op rep admin credit cursor selected stock vend pulses
    int tv [0:63][0:8];
    int n_rows = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;
    // reference model state
    int m_credit, m_cursor, m_sel, m_vend, m_item, m_pulses, m_ret, m_len;
    int m_stock [0:2];
    int vend_seen, item_seen, pulses_seen, ret_seen, ret_len;

    vend_top uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the tests did not finish within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic int price_of(input int item);
        case (item)
            1:       return `VEND_PRICE_COKE;
            2:       return `VEND_PRICE_WATER;
            3:       return `VEND_PRICE_JUICE;
            default: return 0;
        endcase
    endfunction

    task automatic check(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model that applies one key per call
    task automatic update_model(input int op, input int admin);
        int add;
        m_vend = 0;
        m_item = 0;
        m_pulses = 0;
        m_ret = 0;
        m_len = 0;
        add = (op == 4) ? `VEND_COIN_SMALL : (op == 5) ? `VEND_COIN_MID : `VEND_COIN_LARGE;
        case (op)
            1: if (m_cursor > 0) m_cursor--;
            2: if (m_cursor < 2) m_cursor++;
            3: begin
                if (m_sel == m_cursor + 1)
                    m_sel = 0;
                else if (m_stock[m_cursor] > 0)
                    m_sel = m_cursor + 1;
            end
            4, 5, 6: begin
                m_credit = m_credit + add;
                if (m_credit > `VEND_CREDIT_MAX) m_credit = `VEND_CREDIT_MAX;
            end
            7: begin
                if (m_sel != 0 && m_stock[m_sel-1] > 0 && m_credit >= price_of(m_sel)) begin
                    m_vend = 1;
                    m_item = m_sel;
                    m_credit = m_credit - price_of(m_sel);
                    m_stock[m_sel-1]--;
                    m_sel = 0;
                end
            end
            8, 10: begin
                // one pay slot per unit plus the closing cycle
                m_ret = (m_credit > 0);
                m_len = (m_credit > 0) ? m_credit * `VEND_PAYOUT_DIV + 1 : 0;
                m_pulses = m_credit;
                m_credit = 0;
            end
            9: if (admin != 0 && m_stock[m_cursor] < `VEND_STOCK_MAX) m_stock[m_cursor]++;
            default: ;
        endcase
    endtask

    task automatic press(input int op);
        keys = '0;
        case (op)
            1:       keys.up = 1'b1;
            2:       keys.down = 1'b1;
            3:       keys.select = 1'b1;
            4:       keys.coin = COIN_SMALL;
            5:       keys.coin = COIN_MID;
            6:       keys.coin = COIN_LARGE;
            7:       keys.buy = 1'b1;
            8, 10:   keys.ret = 1'b1;
            9:       keys.restock = 1'b1;
            default: ;
        endcase
    endtask

    // counts payout pulses and cycles until returning falls
    task automatic wait_return(input logic send_coin);
        int n;
        n = 0;
        pulses_seen = 0;
        while (returning) begin
            @(posedge clk);
            #1;
            n++;
            if (payout) pulses_seen++;
            // coin in mid payout that the ledger has to drop
            keys.coin = (send_coin && n == 2) ? COIN_LARGE : COIN_NONE;
        end
        ret_len = n;
    endtask

    task automatic run_op(input int op, input int admin);
        @(posedge clk);
        #1;
        admin_mode = admin[0];
        press(op);
        // vend is combinational and sampled mid cycle
        @(negedge clk);
        vend_seen = vend;
        item_seen = vend_item;
        @(posedge clk);
        #1;
        keys = '0;
        ret_seen = returning;
        wait_return(op == 10);
        update_model(op, admin);
        check("vend", vend_seen, m_vend);
        check("vend item", item_seen, m_item);
        check("payout count", pulses_seen, m_pulses);
        check("return length", ret_len, m_len);
        check("credit", credit, m_credit);
        check("cursor", cursor, m_cursor);
        check("selected", selected, m_sel);
        check("stock shown", stock_shown, m_stock[m_cursor]);
        check("returning", ret_seen, m_ret);
    endtask

    //////////////////////////////////////////////////////////////////////
    initial begin
        int fd;
        int r;
        string line;
        clk = 1'b0;
        rst = 1'b0;
        keys = '0;
        admin_mode = 1'b0;
        m_credit = 0;
        m_cursor = 0;
        m_sel = 0;
        m_stock[0] = `VEND_INIT_COKE;
        m_stock[1] = `VEND_INIT_WATER;
        m_stock[2] = `VEND_INIT_JUICE;
        fd = $fopen("tb/vend_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file tb/vend_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_rows < 64) begin
                line = "";
                r = $fgets(line, fd);
                if (r > 0 && line[0] != "#" &&
                    $sscanf(line, "%d %d %d %d %d %d %d %d %d", tv[n_rows][0],
                            tv[n_rows][1], tv[n_rows][2], tv[n_rows][3], tv[n_rows][4],
                            tv[n_rows][5], tv[n_rows][6], tv[n_rows][7],
                            tv[n_rows][8]) == 9) begin
                    limit += 3 * tv[n_rows][1] + `VEND_PAYOUT_DIV * tv[n_rows][8];
                    n_rows++;
                end
            end
            $fclose(fd);
            limit += 100;
            if (n_rows == 0) begin
                $display("the test file holds no test lines");
                errors++;
            end
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b1;
            for (int i = 0; i < n_rows; i++) begin
                for (int k = 0; k < tv[i][1]; k++) run_op(tv[i][0], tv[i][2]);
                // file values hold after the last repetition
                check("credit (file)", credit, tv[i][3]);
                check("cursor (file)", cursor, tv[i][4]);
                check("selected (file)", selected, tv[i][5]);
                check("stock shown (file)", stock_shown, tv[i][6]);
                check("vend (file)", vend_seen, tv[i][7]);
                check("payout count (file)", pulses_seen, tv[i][8]);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb/vend_tests.txt
# op rep admin credit cursor selected stock vend pulses (expected values after the last rep)
# op: 1 up, 2 down, 3 select, 4/5/6 coin 1/5/10, 7 buy, 8 return, 9 restock, 10 return + coin
1 1 0 0 0 0 5 0 0
2 1 0 0 1 0 1 0 0
2 2 0 0 2 0 0 0 0
3 1 0 0 2 0 0 0 0
1 2 0 0 0 0 5 0 0
3 1 0 0 0 1 5 0 0
3 1 0 0 0 0 5 0 0
3 1 0 0 0 1 5 0 0
5 1 0 5 0 1 5 0 0
7 1 0 5 0 1 5 0 0
4 1 0 6 0 1 5 0 0
6 1 0 16 0 1 5 0 0
7 1 0 6 0 0 4 1 0
2 1 0 6 1 0 1 0 0
3 1 0 6 1 2 1 0 0
6 1 0 16 1 2 1 0 0
7 1 0 4 1 0 0 1 0
3 1 0 4 1 0 0 0 0
10 1 0 0 1 0 0 0 4
8 1 0 0 1 0 0 0 0
6 10 0 99 1 0 0 0 0
4 1 0 99 1 0 0 0 0
9 1 0 99 1 0 0 0 0
9 12 1 99 1 0 9 0 0
3 1 0 99 1 2 9 0 0
7 1 0 87 1 0 8 1 0
10 1 0 0 1 0 8 0 87

// File: compile.f
+incdir+include
hdl/vend_pkg.sv
hdl/item_select.sv
hdl/credit_ledger.sv
hdl/vend_arbiter.sv
hdl/vend_top.sv
tb/vend_chk.sv
tb/vend_tb.sv

// File: run.sh
#!/bin/sh
# build and run the vending machine testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module vend_tb; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vvend_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
